// ==== hdl/exu_pkg.sv ====
package exu_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] xlen_t;     // data or address word
  typedef logic [4:0]      reg_idx_t;  // destination register
  typedef logic [11:0]     csr_addr_t;
  typedef logic [2:0]      op_class_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [2:0]      func3_t;

  // operation classes, set by decode
  localparam op_class_t cls_alu    = 3'd0;
  localparam op_class_t cls_branch = 3'd1;
  localparam op_class_t cls_jal    = 3'd2;  // jal and jalr
  localparam op_class_t cls_csr    = 3'd3;
  localparam op_class_t cls_ecall  = 3'd4;
  localparam op_class_t cls_mret   = 3'd5;
  localparam op_class_t cls_ebreak = 3'd6;

  // alu functions
  localparam alu_op_t alu_add  = 4'd0;
  localparam alu_op_t alu_sub  = 4'd1;
  localparam alu_op_t alu_sll  = 4'd2;
  localparam alu_op_t alu_slt  = 4'd3;
  localparam alu_op_t alu_sltu = 4'd4;
  localparam alu_op_t alu_xor  = 4'd5;
  localparam alu_op_t alu_srl  = 4'd6;
  localparam alu_op_t alu_sra  = 4'd7;
  localparam alu_op_t alu_or   = 4'd8;
  localparam alu_op_t alu_and  = 4'd9;

  // branch conditions, same encoding as the instruction func3
  localparam func3_t br_beq  = 3'd0;
  localparam func3_t br_bne  = 3'd1;
  localparam func3_t br_blt  = 3'd4;
  localparam func3_t br_bge  = 3'd5;
  localparam func3_t br_bltu = 3'd6;
  localparam func3_t br_bgeu = 3'd7;

  // csr access kinds, immediate forms arrive as these too
  localparam func3_t csr_rw = 3'd1;
  localparam func3_t csr_rs = 3'd2;
  localparam func3_t csr_rc = 3'd3;

  // machine csrs kept by the system unit
  localparam csr_addr_t csr_mstatus = 12'h300;
  localparam csr_addr_t csr_mtvec   = 12'h305;
  localparam csr_addr_t csr_mepc    = 12'h341;
  localparam csr_addr_t csr_mcause  = 12'h342;

  // mstatus bit positions
  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;

  // environment call from m-mode
  localparam xlen_t cause_ecall_m = 32'd11;

endpackage

// ==== hdl/exu_op_if.sv ====
interface exu_op_if;

  exu_pkg::op_class_t op_class;
  exu_pkg::alu_op_t   alu_op;
  exu_pkg::func3_t    func3;
  exu_pkg::xlen_t     src1;
  exu_pkg::xlen_t     src2;
  exu_pkg::xlen_t     imm;
  exu_pkg::xlen_t     pc;
  exu_pkg::csr_addr_t csr_addr;

  // retire owns the operation register
  modport retire (
    output op_class, alu_op, func3, src1, src2, imm, pc, csr_addr
  );

  modport unit (
    input op_class, alu_op, func3, src1, src2, imm, pc, csr_addr
  );

endinterface

// ==== hdl/exu_int_unit.sv ====
module exu_int_unit (
  exu_op_if.unit          op,
  output exu_pkg::xlen_t  alu_res_o,
  output logic            taken_o,
  output exu_pkg::xlen_t  target_o
);

  exu_pkg::xlen_t alu_val;
  exu_pkg::xlen_t link;
  logic [4:0]     shamt;
  logic           is_eq;
  logic           is_lt;
  logic           is_ltu;
  logic           cond;

  assign shamt  = op.src2[4:0];
  assign is_eq  = (op.src1 == op.src2);
  assign is_lt  = ($signed(op.src1) < $signed(op.src2));
  assign is_ltu = (op.src1 < op.src2);
  assign link   = op.pc + 32'd4;

  always_comb begin
    case (op.alu_op)
      exu_pkg::alu_add:  alu_val = op.src1 + op.src2;
      exu_pkg::alu_sub:  alu_val = op.src1 - op.src2;
      exu_pkg::alu_sll:  alu_val = op.src1 << shamt;
      exu_pkg::alu_slt:  alu_val = {31'd0, is_lt};
      exu_pkg::alu_sltu: alu_val = {31'd0, is_ltu};
      exu_pkg::alu_xor:  alu_val = op.src1 ^ op.src2;
      exu_pkg::alu_srl:  alu_val = op.src1 >> shamt;
      exu_pkg::alu_sra:  alu_val = $signed(op.src1) >>> shamt;
      exu_pkg::alu_or:   alu_val = op.src1 | op.src2;
      exu_pkg::alu_and:  alu_val = op.src1 & op.src2;
      default:           alu_val = '0;
    endcase
  end

  // branch condition from func3
  always_comb begin
    case (op.func3)
      exu_pkg::br_beq:  cond = is_eq;
      exu_pkg::br_bne:  cond = !is_eq;
      exu_pkg::br_blt:  cond = is_lt;
      exu_pkg::br_bge:  cond = !is_lt;
      exu_pkg::br_bltu: cond = is_ltu;
      exu_pkg::br_bgeu: cond = !is_ltu;
      default:          cond = 1'b0;
    endcase
  end

  // jumps write the return address
  assign alu_res_o = (op.op_class == exu_pkg::cls_jal) ? link : alu_val;

  always_comb begin
    case (op.op_class)
      exu_pkg::cls_branch: begin
        taken_o  = cond;
        target_o = op.pc + op.imm;
      end
      exu_pkg::cls_jal: begin
        taken_o  = 1'b1;
        target_o = (op.src1 + op.imm) & ~32'd1;  // jalr clears bit 0
      end
      default: begin
        taken_o  = 1'b0;
        target_o = op.pc + op.imm;
      end
    endcase
  end

endmodule

// ==== hdl/exu_sys_unit.sv ====
module exu_sys_unit (
  input  logic            clk,
  input  logic            rst,
  exu_op_if.unit          op,
  input  logic            commit_i,
  output exu_pkg::xlen_t  rdata_o,
  output logic            redirect_o,
  output exu_pkg::xlen_t  redirect_pc_o,
  output logic            ebreak_o
);

  exu_pkg::xlen_t mstatus;
  exu_pkg::xlen_t mtvec;
  exu_pkg::xlen_t mepc;
  exu_pkg::xlen_t mcause;
  exu_pkg::xlen_t csr_wdata;

  // read port, unknown addresses give zero
  always_comb begin
    case (op.csr_addr)
      exu_pkg::csr_mstatus: rdata_o = mstatus;
      exu_pkg::csr_mtvec:   rdata_o = mtvec;
      exu_pkg::csr_mepc:    rdata_o = mepc;
      exu_pkg::csr_mcause:  rdata_o = mcause;
      default:              rdata_o = '0;
    endcase
  end

  // read-modify-write value
  always_comb begin
    case (op.func3)
      exu_pkg::csr_rw: csr_wdata = op.src1;
      exu_pkg::csr_rs: csr_wdata = rdata_o | op.src1;
      exu_pkg::csr_rc: csr_wdata = rdata_o & ~op.src1;
      default:         csr_wdata = rdata_o;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (commit_i) begin  // side effects once, at output transfer
      case (op.op_class)
        exu_pkg::cls_csr: begin
          case (op.csr_addr)
            exu_pkg::csr_mstatus: mstatus <= csr_wdata;
            exu_pkg::csr_mtvec:   mtvec   <= csr_wdata;
            exu_pkg::csr_mepc:    mepc    <= csr_wdata;
            exu_pkg::csr_mcause:  mcause  <= csr_wdata;
            default: ;                    // writes to other csrs are dropped
          endcase
        end
        exu_pkg::cls_ecall: begin
          mepc   <= op.pc;
          mcause <= exu_pkg::cause_ecall_m;
        end
        exu_pkg::cls_mret: begin
          mstatus[exu_pkg::mstatus_mie]  <= mstatus[exu_pkg::mstatus_mpie];
          mstatus[exu_pkg::mstatus_mpie] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // trap entry and return change the flow
  always_comb begin
    case (op.op_class)
      exu_pkg::cls_ecall: begin
        redirect_o    = 1'b1;
        redirect_pc_o = mtvec;
      end
      exu_pkg::cls_mret: begin
        redirect_o    = 1'b1;
        redirect_pc_o = mepc;
      end
      default: begin
        redirect_o    = 1'b0;
        redirect_pc_o = mtvec;
      end
    endcase
  end

  assign ebreak_o = (op.op_class == exu_pkg::cls_ebreak);

endmodule

// ==== hdl/exu_retire.sv ====
module exu_retire (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid_i,
  output logic                ready_o,
  input  logic                ready_i,
  output logic                valid_o,
  input  exu_pkg::op_class_t  op_class_i,
  input  exu_pkg::alu_op_t    alu_op_i,
  input  exu_pkg::func3_t     func3_i,
  input  exu_pkg::xlen_t      src1_i,
  input  exu_pkg::xlen_t      src2_i,
  input  exu_pkg::xlen_t      imm_i,
  input  exu_pkg::xlen_t      pc_i,
  input  exu_pkg::csr_addr_t  csr_addr_i,
  input  exu_pkg::reg_idx_t   rd_i,
  input  logic                rd_wen_i,
  exu_op_if.retire            op,
  input  exu_pkg::xlen_t      alu_res_i,
  input  logic                taken_i,
  input  exu_pkg::xlen_t      target_i,
  input  exu_pkg::xlen_t      csr_rdata_i,
  input  logic                redirect_i,
  input  exu_pkg::xlen_t      redirect_pc_i,
  input  logic                ebreak_i,
  output logic                commit_o,
  output exu_pkg::reg_idx_t   rd_o,
  output logic                rd_wen_o,
  output exu_pkg::xlen_t      rd_data_o,
  output exu_pkg::xlen_t      npc_o,
  output logic                ebreak_o
);

  logic held;     // a result sits in the register
  logic accept;

  assign ready_o  = !held || ready_i;  // slot frees in the same cycle
  assign accept   = valid_i && ready_o;
  assign commit_o = held && ready_i;
  assign valid_o  = held;

  always_ff @(posedge clk) begin
    if (rst) begin
      held <= 1'b0;
    end else if (accept) begin
      held <= 1'b1;
    end else if (ready_i) begin
      held <= 1'b0;
    end
  end

  // operation register, payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      op.op_class <= op_class_i;
      op.alu_op   <= alu_op_i;
      op.func3    <= func3_i;
      op.src1     <= src1_i;
      op.src2     <= src2_i;
      op.imm      <= imm_i;
      op.pc       <= pc_i;
      op.csr_addr <= csr_addr_i;
      rd_o        <= rd_i;
      rd_wen_o    <= rd_wen_i;
    end
  end

  assign rd_data_o = (op.op_class == exu_pkg::cls_csr) ? csr_rdata_i : alu_res_i;

  // trap redirect wins over branch target
  always_comb begin
    if (redirect_i) begin
      npc_o = redirect_pc_i;
    end else if (taken_i) begin
      npc_o = target_i;
    end else begin
      npc_o = op.pc + 32'd4;
    end
  end

  assign ebreak_o = held && ebreak_i;

endmodule

// ==== hdl/exu_top.sv ====
module exu_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid_i,
  output logic                ready_o,
  input  exu_pkg::op_class_t  op_class_i,
  input  exu_pkg::alu_op_t    alu_op_i,
  input  exu_pkg::func3_t     func3_i,
  input  exu_pkg::xlen_t      src1_i,
  input  exu_pkg::xlen_t      src2_i,
  input  exu_pkg::xlen_t      imm_i,
  input  exu_pkg::xlen_t      pc_i,
  input  exu_pkg::csr_addr_t  csr_addr_i,
  input  exu_pkg::reg_idx_t   rd_i,
  input  logic                rd_wen_i,
  output logic                valid_o,
  input  logic                ready_i,
  output exu_pkg::reg_idx_t   rd_o,
  output logic                rd_wen_o,
  output exu_pkg::xlen_t      rd_data_o,
  output exu_pkg::xlen_t      npc_o,
  output logic                ebreak_o
);

  exu_pkg::xlen_t alu_res;
  exu_pkg::xlen_t target;
  exu_pkg::xlen_t csr_rdata;
  exu_pkg::xlen_t redirect_pc;
  logic           taken;
  logic           redirect;
  logic           sys_ebreak;
  logic           commit;

  exu_op_if op_bus ();  // latched operation

  exu_retire i_exu_retire (
    .clk           (clk),
    .rst           (rst),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .ready_i       (ready_i),
    .valid_o       (valid_o),
    .op_class_i    (op_class_i),
    .alu_op_i      (alu_op_i),
    .func3_i       (func3_i),
    .src1_i        (src1_i),
    .src2_i        (src2_i),
    .imm_i         (imm_i),
    .pc_i          (pc_i),
    .csr_addr_i    (csr_addr_i),
    .rd_i          (rd_i),
    .rd_wen_i      (rd_wen_i),
    .op            (op_bus.retire),
    .alu_res_i     (alu_res),
    .taken_i       (taken),
    .target_i      (target),
    .csr_rdata_i   (csr_rdata),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .ebreak_i      (sys_ebreak),
    .commit_o      (commit),
    .rd_o          (rd_o),
    .rd_wen_o      (rd_wen_o),
    .rd_data_o     (rd_data_o),
    .npc_o         (npc_o),
    .ebreak_o      (ebreak_o)
  );

  exu_int_unit i_exu_int_unit (
    .op        (op_bus.unit),
    .alu_res_o (alu_res),
    .taken_o   (taken),
    .target_o  (target)
  );

  exu_sys_unit i_exu_sys_unit (
    .clk           (clk),
    .rst           (rst),
    .op            (op_bus.unit),
    .commit_i      (commit),
    .rdata_o       (csr_rdata),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .ebreak_o      (sys_ebreak)
  );

endmodule

// ==== bench/exu_sva.sv ====
module exu_sva (
  input logic               clk,
  input logic               rst,
  input logic               valid_i,
  input logic               ready_o,
  input logic               valid_o,
  input logic               ready_i,
  input exu_pkg::reg_idx_t  rd_o,
  input logic               rd_wen_o,
  input exu_pkg::xlen_t     rd_data_o,
  input exu_pkg::xlen_t     npc_o,
  input logic               ebreak_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // a stalled result stays put
  assert property (@(posedge clk) disable iff (rst)
    valid_o && !ready_i |=> valid_o && $stable(rd_o) && $stable(rd_wen_o) &&
    $stable(rd_data_o) && $stable(npc_o) && $stable(ebreak_o))
    else $error("result changed or dropped before ready_i");

  assert property (@(posedge clk) rst |=> !valid_o)
    else $error("valid_o high after reset");

  assert property (@(posedge clk) disable iff (rst) valid_i && ready_o |=> valid_o)
    else $error("accepted issue gave no valid_o one cycle later");

endmodule

bind exu_top exu_sva i_exu_sva (.*);

// ==== bench/exu_tb.sv ====
module exu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    exu_pkg::reg_idx_t rd;
    logic              rd_wen;
    exu_pkg::xlen_t    rd_data;
    exu_pkg::xlen_t    npc;
    logic              ebreak;
  } result_t;

  localparam int wait_limit = 200;

  logic                clk = 1'b0;
  logic                rst;
  logic                valid_i;
  logic                ready_o;
  exu_pkg::op_class_t  op_class_i;
  exu_pkg::alu_op_t    alu_op_i;
  exu_pkg::func3_t     func3_i;
  exu_pkg::xlen_t      src1_i;
  exu_pkg::xlen_t      src2_i;
  exu_pkg::xlen_t      imm_i;
  exu_pkg::xlen_t      pc_i;
  exu_pkg::csr_addr_t  csr_addr_i;
  exu_pkg::reg_idx_t   rd_i;
  logic                rd_wen_i;
  logic                valid_o;
  logic                ready_i;
  exu_pkg::reg_idx_t   rd_o;
  logic                rd_wen_o;
  exu_pkg::xlen_t      rd_data_o;
  exu_pkg::xlen_t      npc_o;
  logic                ebreak_o;

  logic [31:0]         lfsr = 32'd58;
  exu_pkg::xlen_t      m_status = '0;  // csr mirror
  exu_pkg::xlen_t      m_tvec = '0;
  exu_pkg::xlen_t      m_epc = '0;
  exu_pkg::xlen_t      m_cause = '0;
  result_t             exp_q [$];
  string               name_q [$];
  int                  issued = 0;
  int                  retired = 0;

  exu_top i_exu_top (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic exu_pkg::xlen_t csr_value(exu_pkg::csr_addr_t a);
    case (a)
      exu_pkg::csr_mstatus: return m_status;
      exu_pkg::csr_mtvec:   return m_tvec;
      exu_pkg::csr_mepc:    return m_epc;
      exu_pkg::csr_mcause:  return m_cause;
      default:              return '0;
    endcase
  endfunction

  // expected result of the operation on the issue inputs
  function automatic result_t predict();
    result_t        r;
    exu_pkg::xlen_t old;
    exu_pkg::xlen_t wr;
    logic           cond;
    old = csr_value(csr_addr_i);
    case (alu_op_i)
      exu_pkg::alu_add:  r.rd_data = src1_i + src2_i;
      exu_pkg::alu_sub:  r.rd_data = src1_i - src2_i;
      exu_pkg::alu_sll:  r.rd_data = src1_i << src2_i[4:0];
      exu_pkg::alu_slt:  r.rd_data = {31'd0, $signed(src1_i) < $signed(src2_i)};
      exu_pkg::alu_sltu: r.rd_data = {31'd0, src1_i < src2_i};
      exu_pkg::alu_xor:  r.rd_data = src1_i ^ src2_i;
      exu_pkg::alu_srl:  r.rd_data = src1_i >> src2_i[4:0];
      exu_pkg::alu_sra:  r.rd_data = $signed(src1_i) >>> src2_i[4:0];
      exu_pkg::alu_or:   r.rd_data = src1_i | src2_i;
      exu_pkg::alu_and:  r.rd_data = src1_i & src2_i;
      default:           r.rd_data = '0;
    endcase
    case (func3_i)
      3'd0:    cond = (src1_i == src2_i);
      3'd1:    cond = (src1_i != src2_i);
      3'd4:    cond = $signed(src1_i) < $signed(src2_i);
      3'd5:    cond = $signed(src1_i) >= $signed(src2_i);
      3'd6:    cond = src1_i < src2_i;
      3'd7:    cond = src1_i >= src2_i;
      default: cond = 1'b0;
    endcase
    r.rd     = rd_i;
    r.rd_wen = rd_wen_i;
    r.ebreak = (op_class_i == exu_pkg::cls_ebreak);
    r.npc    = pc_i + 32'd4;
    case (op_class_i)
      exu_pkg::cls_branch: if (cond) r.npc = pc_i + imm_i;
      exu_pkg::cls_jal: begin
        r.rd_data = pc_i + 32'd4;
        r.npc     = (src1_i + imm_i) & ~32'd1;
      end
      exu_pkg::cls_csr: begin
        r.rd_data = old;
        case (func3_i)
          3'd1:    wr = src1_i;
          3'd2:    wr = old | src1_i;
          3'd3:    wr = old & ~src1_i;
          default: wr = old;
        endcase
        case (csr_addr_i)
          exu_pkg::csr_mstatus: m_status = wr;
          exu_pkg::csr_mtvec:   m_tvec = wr;
          exu_pkg::csr_mepc:    m_epc = wr;
          exu_pkg::csr_mcause:  m_cause = wr;
          default: ;
        endcase
      end
      exu_pkg::cls_ecall: begin
        r.npc   = m_tvec;
        m_epc   = pc_i;
        m_cause = 32'd11;
      end
      exu_pkg::cls_mret: begin
        r.npc       = m_epc;
        m_status[3] = m_status[7];  // mie takes mpie
        m_status[7] = 1'b1;
      end
      default: ;
    endcase
    return r;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input exu_pkg::xlen_t exp, input exu_pkg::xlen_t act);
    stop_on_error($sformatf("CHECK FAILED %s %s expected %h actual %h", test, field, exp, act));
  endtask

  // drive one operation and hold it until the DUT takes it
  task automatic issue(input exu_pkg::op_class_t cls, input exu_pkg::alu_op_t aop,
                       input exu_pkg::func3_t f3, input exu_pkg::xlen_t s1,
                       input exu_pkg::xlen_t s2, input exu_pkg::xlen_t imm,
                       input exu_pkg::csr_addr_t csr, input string test);
    int waited;
    op_class_i = cls;
    alu_op_i   = aop;
    func3_i    = f3;
    src1_i     = s1;
    src2_i     = s2;
    imm_i      = imm;
    csr_addr_i = csr;
    pc_i       = rand_bits(30) << 2;
    rd_i       = exu_pkg::reg_idx_t'(rand_bits(5));
    rd_wen_i   = rand_bits(1) != 0;
    valid_i    = 1'b1;
    exp_q.push_back(predict());
    name_q.push_back(test);
    issued++;
    waited = 0;
    @(negedge clk);
    while (!ready_o) begin
      waited++;
      if (waited > wait_limit) stop_on_error("timeout waiting for ready_o during issue");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    valid_i = 1'b0;
  endtask

  function automatic exu_pkg::csr_addr_t csr_pick(int k);
    case (k)
      0:       return exu_pkg::csr_mstatus;
      1:       return exu_pkg::csr_mtvec;
      2:       return exu_pkg::csr_mepc;
      3:       return exu_pkg::csr_mcause;
      default: return 12'h7c0;  // not implemented
    endcase
  endfunction

  function automatic exu_pkg::xlen_t operand_pick(int k, int side);
    case (k)
      0:       return 32'd5;
      1:       return side == 0 ? 32'd3 : 32'd9;
      2:       return side == 0 ? 32'd9 : 32'd3;
      3:       return side == 0 ? 32'h8000_0000 : 32'd1;  // sign crossing
      default: return side == 0 ? 32'd1 : 32'h8000_0000;
    endcase
  endfunction

  always @(posedge clk) begin
    #1;
    ready_i = rst ? 1'b1 : (rand_bits(2) != 0);
  end

  always @(negedge clk) begin
    result_t e;
    string   n;
    if (!rst) begin
      assert (ready_o == (!valid_o || ready_i))  // free slot or the held result leaves
        else report_mismatch("handshake", "ready_o", 32'(!valid_o || ready_i), 32'(ready_o));
    end
    if (!rst && valid_o && ready_i) begin
      if (exp_q.size() == 0) stop_on_error("result left the DUT with no operation pending");
      e = exp_q.pop_front();
      n = name_q.pop_front();
      assert (rd_o == e.rd) else report_mismatch(n, "rd", 32'(e.rd), 32'(rd_o));
      assert (rd_wen_o == e.rd_wen) else report_mismatch(n, "rd_wen", 32'(e.rd_wen), 32'(rd_wen_o));
      assert (rd_data_o == e.rd_data) else report_mismatch(n, "rd_data", e.rd_data, rd_data_o);
      assert (npc_o == e.npc) else report_mismatch(n, "npc", e.npc, npc_o);
      assert (ebreak_o == e.ebreak) else report_mismatch(n, "ebreak", 32'(e.ebreak), 32'(ebreak_o));
      retired++;
    end
  end

  initial begin
    int waited;
    rst = 1'b1;
    valid_i = 1'b0;
    ready_i = 1'b1;
    op_class_i = '0;
    alu_op_i = '0;
    func3_i = '0;
    src1_i = '0;
    src2_i = '0;
    imm_i = '0;
    pc_i = '0;
    csr_addr_i = '0;
    rd_i = '0;
    rd_wen_i = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    assert (ready_o && !valid_o) else stop_on_error("handshake outputs wrong after reset");
    for (int k = 0; k < 40; k++) begin
      issue(exu_pkg::cls_alu, exu_pkg::alu_op_t'(rand_bits(4) % 10), 3'd0,
            rand_bits(32), rand_bits(32), rand_bits(32), 12'h000, "alu_random");
    end
    for (int f = 0; f < 8; f++) begin
      for (int p = 0; p < 5; p++) begin
        if (f != 2 && f != 3) begin
          issue(exu_pkg::cls_branch, exu_pkg::alu_add, exu_pkg::func3_t'(f),
                operand_pick(p, 0), operand_pick(p, 1), rand_bits(12) << 1, 12'h000, "branch");
        end
      end
    end
    for (int k = 0; k < 4; k++) begin
      issue(exu_pkg::cls_jal, exu_pkg::alu_add, 3'd0, rand_bits(32), 32'd0,
            rand_bits(20), 12'h000, "jump");
    end
    for (int c = 0; c < 5; c++) begin
      for (int f = 1; f < 4; f++) begin
        issue(exu_pkg::cls_csr, exu_pkg::alu_add, exu_pkg::func3_t'(f), rand_bits(32),
              32'd0, 32'd0, csr_pick(c), "csr_access");
      end
    end
    issue(exu_pkg::cls_csr, exu_pkg::alu_add, 3'd1, 32'h100, 32'd0, 32'd0, 12'h305, "trap_setup");
    issue(exu_pkg::cls_csr, exu_pkg::alu_add, 3'd1, 32'h08, 32'd0, 32'd0, 12'h300, "trap_setup");
    issue(exu_pkg::cls_ecall, exu_pkg::alu_add, 3'd0, 32'd0, 32'd0, 32'd0, 12'h000, "ecall");
    issue(exu_pkg::cls_csr, exu_pkg::alu_add, 3'd2, 32'd0, 32'd0, 32'd0, 12'h341, "trap_read");
    issue(exu_pkg::cls_csr, exu_pkg::alu_add, 3'd2, 32'd0, 32'd0, 32'd0, 12'h342, "trap_read");
    issue(exu_pkg::cls_mret, exu_pkg::alu_add, 3'd0, 32'd0, 32'd0, 32'd0, 12'h000, "mret");
    issue(exu_pkg::cls_csr, exu_pkg::alu_add, 3'd2, 32'd0, 32'd0, 32'd0, 12'h300, "trap_read");
    issue(exu_pkg::cls_ebreak, exu_pkg::alu_add, 3'd0, 32'd1, 32'd2, 32'd0, 12'h000, "ebreak");
    for (int k = 0; k < 60; k++) begin
      issue(exu_pkg::op_class_t'(rand_bits(3) % 7), exu_pkg::alu_op_t'(rand_bits(4) % 10),
            exu_pkg::func3_t'(rand_bits(3)), rand_bits(32), rand_bits(32), rand_bits(32),
            csr_pick(int'(rand_bits(3) % 5)), "mixed_stall");
    end
    waited = 0;
    while (retired != issued && waited < wait_limit) begin
      @(posedge clk);
      waited++;
    end
    if (retired == issued && exp_q.size() == 0) begin
      $display("No errors");
      $finish;
    end else begin
      stop_on_error("timeout waiting for the last results to leave the DUT");
    end
  end

endmodule

// ==== project.f ====
hdl/exu_pkg.sv
hdl/exu_op_if.sv
hdl/exu_int_unit.sv
hdl/exu_sys_unit.sv
hdl/exu_retire.sv
hdl/exu_top.sv
bench/exu_sva.sv
bench/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module exu_tb --Mdir obj_dir -o exu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/exu_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
